// File: verilog/cp_pkg.sv
`default_nettype none

package cp_pkg;

    // data path widths
    localparam int phit_size    = 32;              // data word and immediate width
    localparam int num_col      = 4;               // array columns, one config table each
    localparam int sz_config    = 16;              // column control word

    // table geometry
    localparam int table_depth  = 16;
    localparam int table_aw     = 4;               // log2 of table_depth

    // register file side
    localparam int dwidth_rfadd = 6;               // rf address, also width of entry counts

    // state table enable in bit 0
    // column c owns bits 2c+1 (ctrl) and 2c+2 (imm)
    localparam int num_wr_en    = 2 * num_col + 1;

    // packed iteration output, itr_i in the top bits
    localparam int itr_w        = 64;
    localparam int itr_i_w      = 16;              // outer loop
    localparam int itr_j_w      = 16;              // entry-to-entry loop
    localparam int itr_k_w      = 32;              // inner loop, runs to bound

    localparam int bound_w      = 8;

    // one state table entry, taken from the low bits of a load word
    typedef struct packed {
        logic [bound_w-1:0]  bound;                // last itr_k value of this entry
        logic [table_aw-1:0] next_ptr;             // entry to fetch when not halting
        logic                halt;                 // end of program
    } state_entry_t;

    localparam int entry_sz_state = $bits(state_entry_t);   // 13

    // loop sequencer states
    typedef enum logic [2:0] {
        IDLE,                                      // nothing loaded yet
        READY,                                     // ready_stream_in high
        WAIT_DROP,                                 // start seen, waiting for it to fall
        FETCH,                                     // table read in flight
        STEP                                       // iterations of the current entry
    } seq_state_e;

endpackage

`default_nettype wire

// File: verilog/state_table.sv
`timescale 1ns/1ps
`default_nettype none

module state_table (
    input  logic                          clk,
    input  logic                          wr_en,
    input  logic [cp_pkg::table_aw-1:0]   wr_add,
    input  logic [cp_pkg::table_aw-1:0]   rd_add,
    input  logic [cp_pkg::phit_size-1:0]  wr_data,
    output cp_pkg::state_entry_t          rd_data
);

    import cp_pkg::*;

    // one entry per program state
    state_entry_t mem [table_depth];

    // write port, only the low entry_sz_state bits of the word are kept
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_add] <= state_entry_t'(wr_data[entry_sz_state-1:0]);
        end
    end

    // registered read, entry shows up one cycle after the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_add];
    end

endmodule

`default_nettype wire

// File: verilog/config_table.sv
`timescale 1ns/1ps
`default_nettype none

module config_table (
    input  logic                          clk,
    input  logic [1:0]                    wr_en,        // [0] ctrl word, [1] immediate
    input  logic [cp_pkg::table_aw-1:0]   wr_add,
    input  logic [cp_pkg::table_aw-1:0]   rd_add,
    input  logic [cp_pkg::phit_size-1:0]  wr_data,
    output logic [cp_pkg::sz_config-1:0]  rd_data_ctrl,
    output logic [cp_pkg::phit_size-1:0]  rd_data_imm
);

    import cp_pkg::*;

    // two arrays behind one address
    logic [sz_config-1:0] ctrl_mem [table_depth];
    logic [phit_size-1:0] imm_mem  [table_depth];

    // control word sits in the low bits of the load word
    always_ff @(posedge clk) begin
        if (wr_en[0]) begin
            ctrl_mem[wr_add] <= wr_data[sz_config-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en[1]) begin
            imm_mem[wr_add] <= wr_data;     // full word immediate
        end
    end

    // both reads registered so they line up with the state table
    always_ff @(posedge clk) begin
        rd_data_ctrl <= ctrl_mem[rd_add];
        rd_data_imm  <= imm_mem[rd_add];
    end

endmodule

`default_nettype wire

// File: verilog/table_loader.sv
`timescale 1ns/1ps
`default_nettype none

module table_loader (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             start,          // single cycle pulse
    input  logic                             seq_busy,       // run in progress, ignore start
    input  logic [cp_pkg::dwidth_rfadd-1:0]  num_entry_config_table,
    input  logic [cp_pkg::dwidth_rfadd-1:0]  num_entry_inbound,
    output logic [cp_pkg::num_wr_en-1:0]     tbl_wr_en,      // one-hot during the table phase
    output logic [cp_pkg::table_aw-1:0]      tbl_wr_add,
    output logic                             wr_en_rf,
    output logic [cp_pkg::dwidth_rfadd-1:0]  wr_add_rf,
    output logic                             done
);

    import cp_pkg::*;

    typedef enum logic [1:0] {
        LD_IDLE,
        LD_TABLES,
        LD_INBOUND
    } ld_phase_e;

    ld_phase_e             phase;
    logic [dwidth_rfadd-1:0] n_lat;        // table entries to load
    logic [dwidth_rfadd-1:0] m_lat;        // inbound words to load
    logic [dwidth_rfadd-1:0] entry_cnt;    // current table entry

    assign tbl_wr_add = entry_cnt[table_aw-1:0];
    assign wr_en_rf   = (phase == LD_INBOUND);   // inbound words go straight to the rf

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase     <= LD_IDLE;
            tbl_wr_en <= '0;
            entry_cnt <= '0;
            wr_add_rf <= '0;
            n_lat     <= '0;
            m_lat     <= '0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;                      // pulse by default
            case (phase)
                LD_IDLE: begin
                    // start only counts while no run is using the tables
                    if (start && !seq_busy) begin
                        n_lat     <= num_entry_config_table;
                        m_lat     <= num_entry_inbound;
                        entry_cnt <= '0;
                        wr_add_rf <= '0;
                        if (num_entry_config_table != '0) begin
                            phase     <= LD_TABLES;
                            tbl_wr_en <= num_wr_en'(1);   // first word is the state entry
                        end else if (num_entry_inbound != '0) begin
                            phase <= LD_INBOUND;          // no tables, straight to inbound
                        end else begin
                            done <= 1'b1;                 // empty load
                        end
                    end
                end
                LD_TABLES: begin
                    // walk state, ctrl0, imm0, ctrl1 ... one slot per word
                    tbl_wr_en <= {tbl_wr_en[num_wr_en-2:0], tbl_wr_en[num_wr_en-1]};
                    if (tbl_wr_en[num_wr_en-1]) begin
                        entry_cnt <= entry_cnt + 1'b1;
                        if (entry_cnt == n_lat - 1'b1) begin
                            tbl_wr_en <= '0;              // last imm of last entry
                            if (m_lat != '0) begin
                                phase <= LD_INBOUND;
                            end else begin
                                phase <= LD_IDLE;
                                done  <= 1'b1;
                            end
                        end
                    end
                end
                LD_INBOUND: begin
                    wr_add_rf <= wr_add_rf + 1'b1;
                    if (wr_add_rf == m_lat - 1'b1) begin
                        phase <= LD_IDLE;
                        done  <= 1'b1;                    // cycle after the last rf write
                    end
                end
                default: begin
                    phase     <= LD_IDLE;
                    tbl_wr_en <= '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/loop_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module loop_sequencer (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          load_done,        // pulse from the loader
    input  cp_pkg::state_entry_t          entry_table,      // registered read of smart_ptr
    input  logic                          start_stream_in,
    output logic                          ready_stream_in,
    output logic                          seq_busy,
    output logic                          step_valid,
    output logic [cp_pkg::table_aw-1:0]   smart_ptr,
    output logic [cp_pkg::itr_w-1:0]      itr
);

    import cp_pkg::*;

    seq_state_e            state;
    logic                  loaded;     // at least one load finished since reset
    logic [itr_i_w-1:0]    itr_i;      // completed runs
    logic [itr_j_w-1:0]    itr_j;      // entries walked in this run
    logic [itr_k_w-1:0]    itr_k;      // inner iteration

    logic                  last_step;

    // four-phase exchange, ready is simply the READY state
    assign ready_stream_in = (state == READY);
    assign step_valid      = (state == STEP);
    assign seq_busy        = (state != IDLE) && (state != READY);

    assign itr = {itr_i, itr_j, itr_k};

    // inner loop ends on bound inclusive
    assign last_step = (itr_k == itr_k_w'(entry_table.bound));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= IDLE;
            loaded    <= 1'b0;
            smart_ptr <= '0;
            itr_i     <= '0;
            itr_j     <= '0;
            itr_k     <= '0;
        end else begin
            if (load_done) begin
                loaded <= 1'b1;
            end
            case (state)
                IDLE: begin
                    // nothing to run until the tables hold a program
                    if (load_done || loaded) begin
                        state <= READY;
                    end
                end
                READY: begin
                    if (start_stream_in) begin
                        state <= WAIT_DROP;     // ready falls with this edge
                    end
                end
                WAIT_DROP: begin
                    if (!start_stream_in) begin
                        state <= FETCH;         // smart_ptr is already 0 here
                    end
                end
                FETCH: begin
                    // table read lands at this edge
                    state <= STEP;
                    itr_k <= '0;
                end
                STEP: begin
                    if (!last_step) begin
                        itr_k <= itr_k + 1'b1;
                    end else if (entry_table.halt) begin
                        // end of program, back to entry 0 for the next run
                        itr_i     <= itr_i + 1'b1;
                        itr_j     <= '0;
                        itr_k     <= '0;
                        smart_ptr <= '0;
                        state     <= READY;
                    end else begin
                        itr_j     <= itr_j + 1'b1;
                        itr_k     <= '0;
                        smart_ptr <= entry_table.next_ptr;
                        state     <= FETCH;    // one cycle for the new read
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/control_plane.sv
`timescale 1ns/1ps
`default_nettype none

module control_plane (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  logic [cp_pkg::phit_size-1:0]                   wr_data,
    input  logic                                           start_loader,   // single cycle pulse
    input  logic [cp_pkg::dwidth_rfadd-1:0]                num_entry_config_table,
    input  logic [cp_pkg::dwidth_rfadd-1:0]                num_entry_inbound,
    input  logic                                           start_stream_in,
    output logic                                           ready_stream_in,
    output logic                                           step_valid,
    output logic [cp_pkg::num_col*cp_pkg::sz_config-1:0]   rd_data_ctrl,
    output logic [cp_pkg::num_col*cp_pkg::phit_size-1:0]   rd_data_imm,
    output logic [cp_pkg::entry_sz_state-1:0]              rd_data_state,
    output logic [cp_pkg::itr_w-1:0]                       itr,
    output logic                                           wr_en_rf,
    output logic [cp_pkg::dwidth_rfadd-1:0]                wr_add_rf
);

    import cp_pkg::*;

    logic [num_wr_en-1:0] tbl_wr_en;     // bit 0 state, then ctrl/imm pairs
    logic [table_aw-1:0]  tbl_wr_add;
    logic [table_aw-1:0]  smart_ptr;     // shared read address
    logic                 load_done;
    logic                 seq_busy;

    state_table u_state_table (
        .clk     (clk),
        .wr_en   (tbl_wr_en[0]),
        .wr_add  (tbl_wr_add),
        .rd_add  (smart_ptr),
        .wr_data (wr_data),
        .rd_data (rd_data_state)
    );

    // one table per column, same addresses and data, own enable pair
    for (genvar c = 0; c < num_col; c++) begin : g_col
        config_table u_config_table (
            .clk          (clk),
            .wr_en        (tbl_wr_en[2*c+2:2*c+1]),
            .wr_add       (tbl_wr_add),
            .rd_add       (smart_ptr),
            .wr_data      (wr_data),
            .rd_data_ctrl (rd_data_ctrl[sz_config*c +: sz_config]),
            .rd_data_imm  (rd_data_imm[phit_size*c +: phit_size])
        );
    end

    table_loader u_table_loader (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .start                  (start_loader),
        .seq_busy               (seq_busy),
        .num_entry_config_table (num_entry_config_table),
        .num_entry_inbound      (num_entry_inbound),
        .tbl_wr_en              (tbl_wr_en),
        .tbl_wr_add             (tbl_wr_add),
        .wr_en_rf               (wr_en_rf),
        .wr_add_rf              (wr_add_rf),
        .done                   (load_done)
    );

    loop_sequencer u_loop_sequencer (
        .clk             (clk),
        .rst_n           (rst_n),
        .load_done       (load_done),
        .entry_table     (rd_data_state),
        .start_stream_in (start_stream_in),
        .ready_stream_in (ready_stream_in),
        .seq_busy        (seq_busy),
        .step_valid      (step_valid),
        .smart_ptr       (smart_ptr),
        .itr             (itr)
    );

endmodule

`default_nettype wire

// File: sim/control_plane_chk.sv
`timescale 1ns/1ps
`default_nettype none

module control_plane_chk (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         start_stream_in,
    input logic                         ready_stream_in,
    input logic                         step_valid,
    input logic [cp_pkg::num_wr_en-1:0] tbl_wr_en,
    input logic                         wr_en_rf
);

    // taken start drops ready, run waits for start to fall
    a_ready_drop: assert property (@(posedge clk) disable iff (!rst_n)
        (ready_stream_in && start_stream_in) |=> (!ready_stream_in && !step_valid))
        else $error("ready_stream_in did not drop after start_stream_in");

    a_tbl_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(tbl_wr_en))
        else $error("tbl_wr_en has more than one bit set");

    // table phase and inbound phase are separate
    a_tbl_rf: assert property (@(posedge clk) disable iff (!rst_n)
        !((tbl_wr_en != '0) && wr_en_rf))
        else $error("table write and rf write in the same cycle");

    a_reset_ready: assert property (@(posedge clk) !rst_n |=> !ready_stream_in)
        else $error("ready_stream_in high right after reset");

endmodule

`default_nettype wire

// File: sim/control_plane_tb.sv
`timescale 1ns/1ps
`default_nettype none

module control_plane_tb;

    import cp_pkg::*;

    logic                          clk;
    logic                          rst_n;
    logic [phit_size-1:0]          wr_data;
    logic                          start_loader;
    logic [dwidth_rfadd-1:0]       num_entry_config_table;
    logic [dwidth_rfadd-1:0]       num_entry_inbound;
    logic                          start_stream_in;
    logic                          ready_stream_in;
    logic                          step_valid;
    logic [num_col*sz_config-1:0]  rd_data_ctrl;
    logic [num_col*phit_size-1:0]  rd_data_imm;
    logic [entry_sz_state-1:0]     rd_data_state;
    logic [itr_w-1:0]              itr;
    logic                          wr_en_rf;
    logic [dwidth_rfadd-1:0]       wr_add_rf;

    int seed      = 32'hab41117d;
    int run_idx;                      // finished runs, expected itr_i
    int rf_writes = 0;                // every write the external rf has seen

    // models, state entry packs as bound [12:5], next_ptr [4:1], halt [0]
    logic [entry_sz_state-1:0] st_m   [table_depth];
    logic [sz_config-1:0]      ctrl_m [num_col][table_depth];
    logic [phit_size-1:0]      imm_m  [num_col][table_depth];
    logic [phit_size-1:0]      inb_m  [2**dwidth_rfadd];
    logic [phit_size-1:0]      rf_mem [2**dwidth_rfadd];     // external register file

    control_plane dut0 (.*);

    bind control_plane control_plane_chk u_chk (
        .clk             (clk),
        .rst_n           (rst_n),
        .start_stream_in (start_stream_in),
        .ready_stream_in (ready_stream_in),
        .step_valid      (step_valid),
        .tbl_wr_en       (tbl_wr_en),
        .wr_en_rf        (wr_en_rf)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        if (wr_en_rf) begin
            rf_mem[wr_add_rf] <= wr_data;
            rf_writes         <= rf_writes + 1;
        end
    end

    task automatic fail_stop();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH %s actual=%h expected=%h", name, actual, expected);
            fail_stop();
        end
    endtask

    function automatic int rand_below(input int k);
        return $unsigned($random(seed)) % k;
    endfunction

    task automatic wait_ready(input int limit);
        int n;
        n = 0;
        while (!ready_stream_in) begin
            @(negedge clk);
            n++;
            if (n > limit) begin
                $display("ready_stream_in never rose within %0d cycles", limit);
                fail_stop();
            end
        end
    endtask

    // random chain from entry 0 to a halt entry, then one word per cycle
    task automatic load_program(input int n, input int m);
        logic [phit_size-1:0] words [$];
        logic [phit_size-1:0] w;
        int perm [table_depth];
        int len, r, tmp, base, per_entry;
        per_entry = 1 + 2 * num_col;                // state word then ctrl/imm per column
        for (int e = 0; e < table_depth; e++)
            perm[e] = e;
        for (int i = n - 1; i > 1; i--) begin        // entry 0 stays in front
            r       = 1 + rand_below(i);
            tmp     = perm[i];
            perm[i] = perm[r];
            perm[r] = tmp;
        end
        len = 1 + rand_below(n);
        for (int e = 0; e < n; e++)
            st_m[e] = {8'(rand_below(8)), 4'(rand_below(16)), 1'(rand_below(2))};
        for (int i = 0; i < len; i++) begin
            if (i == len - 1)
                st_m[perm[i]][4:0] = 5'b00001;      // halt closes the chain
            else
                st_m[perm[i]][4:0] = {4'(perm[i+1]), 1'b0};
        end
        for (int e = 0; e < n; e++) begin
            w = $random(seed);
            w[entry_sz_state-1:0] = st_m[e];         // upper bits are junk, must be dropped
            words.push_back(w);
            for (int c = 0; c < num_col; c++) begin
                w = $random(seed);
                ctrl_m[c][e] = w[sz_config-1:0];
                words.push_back(w);
                w = $random(seed);
                imm_m[c][e] = w;
                words.push_back(w);
            end
        end
        for (int i = 0; i < m; i++) begin
            inb_m[i] = $random(seed);
            words.push_back(inb_m[i]);
        end
        base = rf_writes;
        @(negedge clk);
        start_loader           = 1'b1;
        num_entry_config_table = 6'(n);
        num_entry_inbound      = 6'(m);
        for (int k = 1; k <= words.size(); k++) begin
            @(negedge clk);
            start_loader = 1'b0;
            wr_data      = words[k-1];                // sampled at the k-th edge
            check_equal("wr_en_rf", 128'(wr_en_rf), 128'(k > per_entry * n));
            if (k > per_entry * n)
                check_equal("wr_add_rf", 128'(wr_add_rf), 128'(k - per_entry * n - 1));
        end
        @(negedge clk);
        check_equal("wr_en_rf", 128'(wr_en_rf), 128'(0));
        wait_ready(10);
        check_equal("rf_write_count", 128'(rf_writes - base), 128'(m));
        for (int i = 0; i < m; i++)
            check_equal("rf_data", 128'(rf_mem[i]), 128'(inb_m[i]));
    endtask

    task automatic run_program(input bit poke_loader);
        int ptr, j, k, steps, expect_steps, cycles;
        bit active;
        logic [num_col*sz_config-1:0] exp_ctrl;
        logic [num_col*phit_size-1:0] exp_imm;
        ptr          = 0;
        expect_steps = 0;
        for (int i = 0; i < table_depth; i++) begin  // chain length is at most the depth
            expect_steps += int'(st_m[ptr][12:5]) + 1;
            if (st_m[ptr][0])
                break;
            ptr = int'(st_m[ptr][4:1]);
        end
        wait_ready(20);
        @(negedge clk);
        start_stream_in = 1'b1;
        @(negedge clk);
        check_equal("ready_stream_in", 128'(ready_stream_in), 128'(0));
        start_stream_in        = 1'b0;
        start_loader           = poke_loader;         // sequencer busy at this edge
        num_entry_config_table = 6'd1;
        num_entry_inbound      = 6'd5;
        ptr    = 0;
        j      = 0;
        k      = 0;
        steps  = 0;
        cycles = 0;
        active = 1'b1;
        while (1) begin
            @(negedge clk);
            start_loader = 1'b0;
            cycles++;
            if (ready_stream_in)
                break;
            if (cycles > 1000) begin
                $display("run did not return to ready within 1000 cycles");
                fail_stop();
            end
            check_equal("wr_en_rf", 128'(wr_en_rf), 128'(0));
            if (step_valid) begin
                if (!active) begin
                    $display("step_valid still high after the halt entry finished");
                    fail_stop();
                end
                for (int c = 0; c < num_col; c++) begin
                    exp_ctrl[sz_config*c +: sz_config] = ctrl_m[c][ptr];
                    exp_imm[phit_size*c +: phit_size]  = imm_m[c][ptr];
                end
                check_equal("rd_data_state", 128'(rd_data_state), 128'(st_m[ptr]));
                check_equal("rd_data_ctrl", 128'(rd_data_ctrl), 128'(exp_ctrl));
                check_equal("rd_data_imm", rd_data_imm, exp_imm);
                check_equal("itr", 128'(itr), 128'({16'(run_idx), 16'(j), 32'(k)}));
                steps++;
                if (k < int'(st_m[ptr][12:5])) begin
                    k++;
                end else if (st_m[ptr][0]) begin
                    active = 1'b0;                     // ready should follow
                end else begin
                    ptr = int'(st_m[ptr][4:1]);
                    j++;
                    k = 0;
                end
            end
        end
        check_equal("step_count", 128'(steps), 128'(expect_steps));
        run_idx++;
    endtask

    initial begin
        rst_n                  = 1'b0;
        wr_data                = '0;
        start_loader           = 1'b0;
        num_entry_config_table = '0;
        num_entry_inbound      = '0;
        start_stream_in        = 1'b0;
        run_idx                = 0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_equal("ready_stream_in", 128'(ready_stream_in), 128'(0));
        check_equal("step_valid", 128'(step_valid), 128'(0));
        check_equal("wr_en_rf", 128'(wr_en_rf), 128'(0));
        // nothing loaded, start must not open the handshake
        start_stream_in = 1'b1;
        @(negedge clk);
        start_stream_in = 1'b0;
        repeat (20) begin
            @(negedge clk);
            check_equal("ready_stream_in", 128'(ready_stream_in), 128'(0));
        end
        load_program(1 + rand_below(table_depth), rand_below(64));
        run_program(1'b0);
        run_program(1'b0);                               // itr_i 1
        run_program(1'b1);                               // itr_i 2, loader poked mid run
        repeat (10) begin
            @(negedge clk);
            check_equal("wr_en_rf", 128'(wr_en_rf), 128'(0));
        end
        load_program(1 + rand_below(table_depth), rand_below(64));
        run_program(1'b0);
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// File: ctrl_plane.f
verilog/cp_pkg.sv
verilog/state_table.sv
verilog/config_table.sv
verilog/table_loader.sv
verilog/loop_sequencer.sv
verilog/control_plane.sv
sim/control_plane_chk.sv
sim/control_plane_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the control plane testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module control_plane_tb \
    -f ctrl_plane.f -o control_plane_sim \
    && ./obj_dir/control_plane_sim 2>&1 | tee sim.log \
    || echo "build or simulation failed"
grep -q "All tests passed!" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
